// File: verilog/zx_defs.svh
// ========================================
// Shared constants of the ZX Spectrum 128 memory and port side
// Port addresses are full 16-bit values, decoders pick the bits they need
// ROM lives above all RAM pages, so a ROM address has bits 24:20 set
// to the ROM region and RAM pages stay below 0x100000
// ========================================

`ifndef ZX_DEFS_SVH
`define ZX_DEFS_SVH

// ========================================
// Widths
// ========================================

// Z80 address bus
`define ZX_ADDR_W 16

// External RAM address bus
`define ZX_RAM_ADDR_W 25

// Page number, 3 bits of 0x7FFD plus 3 extension bits
`define ZX_PAGE_W 6

// Offset inside one 16K bank
`define ZX_BANK_OFS_W 14

// ========================================
// Ports
// ========================================

// 128K paging, partially decoded on bits 15 and 1
`define ZX_PORT_PAGE 16'h7FFD

// Profi 1024K extended paging, fully decoded
`define ZX_PORT_PAGE_EXT 16'hDFFD

// Kempston joystick, low six address bits only
`define ZX_PORT_KEMPSTON 6'h1F

// ========================================
// Memory map
// ========================================

`define ZX_ROM_REGION 5'h17
`define ZX_PAGE_BANK1 6'd5
`define ZX_PAGE_BANK2 6'd2

// Value seen on an undriven data bus
`define ZX_IDLE_DATA 8'hFF

`endif

// File: verilog/zx_bus_pkg.sv
// ========================================
// Bus level types seen at the Z80 pins and at the loader
// All strobes here are active high, so a bus model must invert
// the real Z80 pins before driving them in
// ========================================

`include "zx_defs.svh"

package zx_bus_pkg;

	// ========================================
	// CPU bus cycle
	// ========================================

	// One cycle as the Z80 presents it
	// data is the write data, only valid while wr is high
	typedef struct packed {
		logic [`ZX_ADDR_W-1:0] addr;
		logic [7:0]            data;
		logic                  mreq;
		logic                  iorq;
		logic                  rd;
		logic                  wr;
		logic                  m1;
	} cpu_bus_t;

	// ========================================
	// Loader override
	// ========================================

	// Takes the RAM port away from the CPU while active is high
	typedef struct packed {
		logic                      active;
		logic [`ZX_RAM_ADDR_W-1:0] addr;
		logic [7:0]                data;
		logic                      wr;
	} loader_t;

endpackage

// File: verilog/zx_mem_pkg.sv
// ========================================
// Memory side types: machine model, paging state and RAM requests
// The RAM request assumes a RAM that completes within the bus cycle
// ========================================

`include "zx_defs.svh"

package zx_mem_pkg;

	// Machine model, sampled while reset is high
	typedef enum logic [1:0] {
		std_128k      = 2'd0,
		pentagon_512k = 2'd1,
		profi_1024k   = 2'd2,
		std_48k       = 2'd3
	} mem_model_t;

	// Current paging
	// page_ram holds the extension bits above the three low bits of 0x7FFD
	typedef struct packed {
		logic [`ZX_PAGE_W-1:0] page_ram;
		logic [1:0]            rom_sel;
		logic                  page_scr;
		logic                  locked;
	} page_state_t;

	// One access to external RAM
	typedef struct packed {
		logic [`ZX_RAM_ADDR_W-1:0] addr;
		logic [7:0]                din;
		logic                      we;
		logic                      rd;
	} ram_req_t;

endpackage

// File: verilog/zx_paging.sv
// ========================================
// Paging registers for 0x7FFD and 0xDFFD
// The machine model is sampled only while reset is high
// A port write acts on the rising edge of the I/O write strobe,
// so back to back writes need an idle cycle in between
// The lock bit is cleared by reset only
// ========================================

`timescale 1ns/10ps

`include "zx_defs.svh"

module zx_paging (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  zx_bus_pkg::cpu_bus_t     cpu,
	input  zx_mem_pkg::mem_model_t   mem_model,
	output zx_mem_pkg::page_state_t  page
);

	zx_mem_pkg::mem_model_t model_q;

	// Bits 5:0 of the last accepted 0x7FFD write
	logic [5:0] page_reg;

	// Extension bits above page_reg[2:0]
	logic [2:0] page_ext;

	logic io_wr;
	logic io_wr_q;
	logic io_wr_edge;
	logic page_sel;
	logic page_ext_sel;
	logic page_en;

	// ========================================
	// Decode
	// ========================================

	assign io_wr      = cpu.iorq & cpu.wr & ~cpu.m1;
	assign io_wr_edge = io_wr & ~io_wr_q;

	// Partial decode, any address with no 1 where 0x7FFD has a 0
	assign page_sel     = ~|(cpu.addr & ~`ZX_PORT_PAGE);
	assign page_ext_sel = (cpu.addr == `ZX_PORT_PAGE_EXT);

	// 48K machines and a locked register ignore 0x7FFD
	assign page_en = ~page_reg[5] & (model_q != zx_mem_pkg::std_48k);

	// ========================================
	// Registers
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q  <= mem_model;
			page_reg <= '0;
			page_ext <= '0;
			io_wr_q  <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			if (io_wr_edge) begin
				if (page_sel && page_en) begin
					page_reg <= cpu.data[5:0];
					// Pentagon keeps two more page bits in the top of 0x7FFD
					if (model_q == zx_mem_pkg::pentagon_512k)
						page_ext[1:0] <= cpu.data[7:6];
				end
				if (page_ext_sel && (model_q == zx_mem_pkg::profi_1024k))
					page_ext <= cpu.data[2:0];
			end
		end
	end

	assign page.page_ram = {page_ext, page_reg[2:0]};
	assign page.page_scr = page_reg[3];
	assign page.locked   = page_reg[5];
	// ROM 3 is the 48K BASIC ROM, ROM 2 the 128K editor
	assign page.rom_sel  = ((model_q == zx_mem_pkg::std_48k) || page_reg[4]) ? 2'd3 : 2'd2;

	// A Z80 never reads and writes in the same cycle
	bus_rd_wr_exclusive: assert property (
		@(posedge clk_sys) disable iff (reset) !(cpu.rd && cpu.wr)
	);

endmodule

// File: verilog/zx_mem_map.sv
// ========================================
// CPU address translation into the 25-bit external RAM space
// Purely combinational, the loader has priority over the CPU
// Bank 0 is ROM and never written by the CPU
// ========================================

`timescale 1ns/10ps

`include "zx_defs.svh"

module zx_mem_map (
	input  zx_bus_pkg::cpu_bus_t     cpu,
	input  zx_bus_pkg::loader_t      loader,
	input  zx_mem_pkg::page_state_t  page,
	output zx_mem_pkg::ram_req_t     ram
);

	logic [1:0]                  bank;
	logic [`ZX_BANK_OFS_W-1:0]   ofs;

	assign bank = cpu.addr[15:14];
	assign ofs  = cpu.addr[`ZX_BANK_OFS_W-1:0];

	always_comb begin
		if (loader.active) begin
			ram.addr = loader.addr;
			ram.din  = loader.data;
			ram.we   = loader.wr;
			ram.rd   = 1'b0;
		end else begin
			case (bank)
				// ROM region on top, four padding bits, then the ROM number
				2'd0: ram.addr = {`ZX_ROM_REGION, 4'b0000, page.rom_sel, ofs};
				2'd1: ram.addr = {5'b00000, `ZX_PAGE_BANK1, ofs};
				2'd2: ram.addr = {5'b00000, `ZX_PAGE_BANK2, ofs};
				default: ram.addr = {5'b00000, page.page_ram, ofs};
			endcase
			ram.din = cpu.data;
			ram.rd  = cpu.mreq & cpu.rd;
			ram.we  = cpu.mreq & cpu.wr & (bank != 2'd0);
		end
	end

endmodule

// File: verilog/zx_io_read.sv
// ========================================
// Read data multiplexer for the Z80 data bus
// RAM read data must be valid within the same bus cycle
// Interrupt acknowledge cycles read the idle value
// ========================================

`timescale 1ns/10ps

`include "zx_defs.svh"

module zx_io_read (
	input  zx_bus_pkg::cpu_bus_t  cpu,
	input  logic [7:0]            ram_dout,
	input  logic [4:0]            key_data,
	input  logic [5:0]            joystick,
	input  logic                  tape_in,
	output logic [7:0]            cpu_din
);

	logic io_rd;
	logic kempston_sel;
	logic ula_sel;

	// m1 together with iorq is an interrupt acknowledge, not a port read
	assign io_rd        = cpu.iorq & cpu.rd & ~cpu.m1;
	assign kempston_sel = (cpu.addr[5:0] == `ZX_PORT_KEMPSTON);
	assign ula_sel      = ~cpu.addr[0];

	// Priority order matters here
	always_comb begin
		if (cpu.mreq)
			cpu_din = ram_dout;
		else if (io_rd && kempston_sel)
			cpu_din = {2'b00, joystick};
		else if (io_rd && ula_sel)
			// Keyboard row, EAR input in bit 6, bits 7 and 5 float high
			cpu_din = {1'b1, ~tape_in, 1'b1, key_data};
		else
			cpu_din = `ZX_IDLE_DATA;
	end

endmodule

// File: verilog/zx_ula_audio.sv
// ========================================
// ULA port latch and audio mixer
// Any even port address reaches the ULA
// Audio is unsigned, the 10-bit mix sits in the top bits
// ========================================

`timescale 1ns/10ps

module zx_ula_audio (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_bus_pkg::cpu_bus_t  cpu,
	input  logic                  tape_in,
	input  logic [7:0]            psg_a,
	input  logic [7:0]            psg_b,
	input  logic [7:0]            psg_c,
	output logic [2:0]            border,
	output logic [15:0]           audio_l,
	output logic [15:0]           audio_r
);

	logic ula_we;
	logic ula_we_q;
	logic ear_out;
	logic mic_out;
	logic [7:0] beeper;

	// Side channel counts twice, centre channel B once
	function automatic logic [9:0] mix(input logic [7:0] side, input logic [7:0] centre,
		input logic [7:0] beep);
		mix = {1'b0, side, 1'b0} + {2'b00, centre} + {2'b00, beep};
	endfunction

	assign ula_we = cpu.iorq & cpu.wr & ~cpu.m1 & ~cpu.addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border   <= 3'd0;
			mic_out  <= 1'b0;
			ear_out  <= 1'b0;
			ula_we_q <= 1'b0;
		end else begin
			ula_we_q <= ula_we;
			if (ula_we && !ula_we_q) begin
				border  <= cpu.data[2:0];
				mic_out <= cpu.data[3];
				ear_out <= cpu.data[4];
			end
		end
	end

	assign beeper  = {ear_out, mic_out, tape_in, 5'b00000};
	assign audio_l = {mix(psg_a, psg_b, beeper), 6'd0};
	assign audio_r = {mix(psg_c, psg_b, beeper), 6'd0};

endmodule

// File: verilog/zx_host.sv
// ========================================
// ZX Spectrum 128 host, memory and port side
// Surrounds an external Z80 bus with active-high strobes
// External RAM must answer within the bus cycle, there is no wait
// The machine model is taken while reset is high
// ========================================

`timescale 1ns/10ps

module zx_host (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  zx_bus_pkg::cpu_bus_t     cpu,
	input  zx_bus_pkg::loader_t      loader,
	input  zx_mem_pkg::mem_model_t   mem_model,
	input  logic [7:0]               ram_dout,
	input  logic [4:0]               key_data,
	input  logic [5:0]               joystick,
	input  logic                     tape_in,
	input  logic [7:0]               psg_a,
	input  logic [7:0]               psg_b,
	input  logic [7:0]               psg_c,
	output zx_mem_pkg::ram_req_t     ram,
	output logic [7:0]               cpu_din,
	output logic [2:0]               border,
	output logic [15:0]              audio_l,
	output logic [15:0]              audio_r
);

	zx_mem_pkg::page_state_t page;

	// ========================================
	// Memory
	// ========================================

	zx_paging u_paging (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu       (cpu),
		.mem_model (mem_model),
		.page      (page)
	);

	zx_mem_map u_mem_map (
		.cpu    (cpu),
		.loader (loader),
		.page   (page),
		.ram    (ram)
	);

	// ========================================
	// Ports and audio
	// ========================================

	zx_io_read u_io_read (
		.cpu      (cpu),
		.ram_dout (ram_dout),
		.key_data (key_data),
		.joystick (joystick),
		.tape_in  (tape_in),
		.cpu_din  (cpu_din)
	);

	zx_ula_audio u_ula_audio (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu     (cpu),
		.tape_in (tape_in),
		.psg_a   (psg_a),
		.psg_b   (psg_b),
		.psg_c   (psg_c),
		.border  (border),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

// File: verification/tb_zx_vectors.svh
// ========================================
// Bus operations and expected results, one row per operation
// Included inside the testbench module
// Port writes must be separated by a non-write row
// Reset rows hold reset for both cycles and capture the model
// ========================================

`ifndef TB_ZX_VECTORS_SVH
`define TB_ZX_VECTORS_SVH

// Strobes as {mreq, iorq, rd, wr, m1}
localparam logic [4:0] S_IDLE = 5'b00000;
localparam logic [4:0] S_MRD  = 5'b10100;
localparam logic [4:0] S_MWR  = 5'b10010;
localparam logic [4:0] S_IRD  = 5'b01100;
localparam logic [4:0] S_IWR  = 5'b01010;

localparam zx_mem_pkg::mem_model_t M128 = zx_mem_pkg::std_128k;
localparam zx_mem_pkg::mem_model_t M512 = zx_mem_pkg::pentagon_512k;
localparam zx_mem_pkg::mem_model_t M1024 = zx_mem_pkg::profi_1024k;
localparam zx_mem_pkg::mem_model_t M48 = zx_mem_pkg::std_48k;

typedef struct packed {
	logic                   rst;
	zx_mem_pkg::mem_model_t model;
	logic [15:0]            addr;
	logic [7:0]             data;
	logic [4:0]             strb;
	logic                   ld_act;
	logic [24:0]            ld_addr;
	logic [7:0]             ld_data;
	logic                   ld_wr;
	logic [7:0]             ram_dout;
	logic [4:0]             key;
	logic [5:0]             joy;
	logic                   tape;
	logic                   chk_mem;
	logic [24:0]            exp_addr;
	logic [7:0]             exp_wdata;
	logic                   exp_we;
	logic                   exp_rd;
	logic                   chk_din;
	logic [7:0]             exp_din;
	logic [2:0]             exp_border;
	logic                   exp_ear;
	logic                   exp_mic;
} vec_t;

localparam int NUM_VEC = 32;

// Line 1: rst model addr data strb ld_act ld_addr ld_data ld_wr ram_dout key joy tape
// Line 2: chk_mem addr wdata we rd chk_din din border ear mic
localparam vec_t VECTORS [NUM_VEC] = '{
	// 128K after reset
	'{'0, M128, 16'hC123, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h0000123, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	'{'0, M128, 16'h0100, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'hA5, 5'h00, 6'h00, '0,
		'1, 25'h1708100, 8'h00, '0, '1, '1, 8'hA5, 3'd0, '0, '0},
	'{'0, M128, 16'h1000, 8'h55, S_MWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'1, 25'h1709000, 8'h55, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	// Paging and lock
	'{'0, M128, 16'h7FFD, 8'h13, S_IWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M128, 16'hC123, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h000C123, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	'{'0, M128, 16'h0100, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h170C100, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	'{'0, M128, 16'h7FFD, 8'h24, S_IWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M128, 16'hC123, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h0010123, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	'{'0, M128, 16'h7FFD, 8'h07, S_IWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M128, 16'hC123, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h0010123, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	'{'0, M128, 16'h0100, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h1708100, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	// Pentagon 512K
	'{'1, M512, 16'h0000, 8'h00, S_IDLE, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M512, 16'h7FFD, 8'hC1, S_IWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M512, 16'hC123, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h0064123, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	// Profi 1024K
	'{'1, M1024, 16'h0000, 8'h00, S_IDLE, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M1024, 16'h7FFD, 8'h01, S_IWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M1024, 16'hC123, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h0004123, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	'{'0, M1024, 16'hDFFD, 8'h05, S_IWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M1024, 16'hC123, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h00A4123, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	// 48K ignores 0x7FFD
	'{'1, M48, 16'h0000, 8'h00, S_IDLE, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M48, 16'h7FFD, 8'h07, S_IWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M48, 16'hC123, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h0000123, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	'{'0, M48, 16'h0100, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h3C, 5'h00, 6'h00, '0,
		'1, 25'h170C100, 8'h00, '0, '1, '1, 8'h3C, 3'd0, '0, '0},
	// ULA port, read data and loader
	'{'1, M128, 16'h0000, 8'h00, S_IDLE, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd0, '0, '0},
	'{'0, M128, 16'h00FE, 8'h1A, S_IWR, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '0, 8'h00, 3'd2, '1, '1},
	'{'0, M128, 16'h8000, 8'h00, S_MRD, '0, 25'h0, 8'h00, '0, 8'h5A, 5'h00, 6'h00, '0,
		'1, 25'h0008000, 8'h00, '0, '1, '1, 8'h5A, 3'd2, '1, '1},
	'{'0, M128, 16'h001F, 8'h00, S_IRD, '0, 25'h0, 8'h00, '0, 8'h00, 5'h00, 6'h2B, '0,
		'0, 25'h0, 8'h00, '0, '0, '1, 8'h2B, 3'd2, '1, '1},
	'{'0, M128, 16'h00FE, 8'h00, S_IRD, '0, 25'h0, 8'h00, '0, 8'h00, 5'h15, 6'h00, '0,
		'0, 25'h0, 8'h00, '0, '0, '1, 8'hF5, 3'd2, '1, '1},
	'{'0, M128, 16'h00FE, 8'h00, S_IRD, '0, 25'h0, 8'h00, '0, 8'h00, 5'h15, 6'h00, '1,
		'0, 25'h0, 8'h00, '0, '0, '1, 8'hB5, 3'd2, '1, '1},
	'{'0, M128, 16'h00FF, 8'h00, S_IRD, '0, 25'h0, 8'h00, '0, 8'h00, 5'h15, 6'h2B, '1,
		'0, 25'h0, 8'h00, '0, '0, '1, 8'hFF, 3'd2, '1, '1},
	'{'0, M128, 16'h4000, 8'h11, S_MWR, '1, 25'h1ABCDE, 8'h77, '1, 8'h00, 5'h00, 6'h00, '0,
		'1, 25'h1ABCDE, 8'h77, '1, '0, '0, 8'h00, 3'd2, '1, '1},
	'{'0, M128, 16'hC000, 8'h00, S_MRD, '1, 25'h0123456, 8'h99, '0, 8'h44, 5'h00, 6'h00, '0,
		'1, 25'h0123456, 8'h99, '0, '0, '1, 8'h44, 3'd2, '1, '1}
};

`endif

// File: verification/tb_zx_host.sv
// ========================================
// Testbench for the ZX Spectrum 128 host
// Each table row is held for two cycles, combinational
// outputs are checked in the first and latched ones in the second
// ========================================

`timescale 1ns/10ps

module tb_zx_host;

	`include "tb_zx_vectors.svh"

	localparam int TIMEOUT_CYCLES = NUM_VEC * 2 + 3 + 20;

	logic                    clk_sys;
	logic                    reset;
	zx_bus_pkg::cpu_bus_t    cpu;
	zx_bus_pkg::loader_t     loader;
	zx_mem_pkg::mem_model_t  mem_model;
	logic [7:0]              ram_dout;
	logic [4:0]              key_data;
	logic [5:0]              joystick;
	logic                    tape_in;
	logic [7:0]              psg_a;
	logic [7:0]              psg_b;
	logic [7:0]              psg_c;
	zx_mem_pkg::ram_req_t    ram;
	logic [7:0]              cpu_din;
	logic [2:0]              border;
	logic [15:0]             audio_l;
	logic [15:0]             audio_r;

	int          errors = 0;
	int          rows_done = 0;
	int          cycle_count = 0;
	logic [31:0] rng_state;

	zx_host uut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu       (cpu),
		.loader    (loader),
		.mem_model (mem_model),
		.ram_dout  (ram_dout),
		.key_data  (key_data),
		.joystick  (joystick),
		.tape_in   (tape_in),
		.psg_a     (psg_a),
		.psg_b     (psg_b),
		.psg_c     (psg_c),
		.ram       (ram),
		.cpu_din   (cpu_din),
		.border    (border),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

	always #10 clk_sys = ~clk_sys;

	// Run limit
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the test did not finish", cycle_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Twice the side channel, plus B, plus the beeper bits at weight 32
	function automatic logic [15:0] expected_audio(input logic [7:0] side, input logic [7:0] centre,
		input logic ear, input logic mic, input logic tape);
		int s;
		s = 2 * int'(side) + int'(centre) + 32 * int'({ear, mic, tape});
		return {s[9:0], 6'b000000};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors++;
		$display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
	endtask

	initial begin
		vec_t        v;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		clk_sys   = 1'b0;
		reset     = 1'b1;
		cpu       = '0;
		loader    = '0;
		mem_model = zx_mem_pkg::std_128k;
		ram_dout  = 8'h00;
		key_data  = 5'h00;
		joystick  = 6'h00;
		tape_in   = 1'b0;
		psg_a     = 8'h00;
		psg_b     = 8'h00;
		psg_c     = 8'h00;
		rng_state = 32'd37289;

		repeat (3) @(posedge clk_sys);
		#2;

		for (int i = 0; i < NUM_VEC; i++) begin
			v = VECTORS[i];
			rng_state = xorshift32(rng_state);
			reset     = v.rst;
			mem_model = v.model;
			cpu.addr  = v.addr;
			cpu.data  = v.data;
			{cpu.mreq, cpu.iorq, cpu.rd, cpu.wr, cpu.m1} = v.strb;
			loader.active = v.ld_act;
			loader.addr   = v.ld_addr;
			loader.data   = v.ld_data;
			loader.wr     = v.ld_wr;
			ram_dout = v.ram_dout;
			key_data = v.key;
			joystick = v.joy;
			tape_in  = v.tape;
			psg_a    = rng_state[7:0];
			psg_b    = rng_state[15:8];
			psg_c    = rng_state[23:16];

			// First cycle, combinational outputs
			#12;
			if (v.chk_mem && ram.addr !== v.exp_addr)
				report_mismatch("ram.addr", 32'(v.exp_addr), 32'(ram.addr));
			if (v.chk_mem && ram.din !== v.exp_wdata)
				report_mismatch("ram.din", 32'(v.exp_wdata), 32'(ram.din));
			if (v.chk_mem && ram.we !== v.exp_we)
				report_mismatch("ram.we", 32'(v.exp_we), 32'(ram.we));
			if (v.chk_mem && ram.rd !== v.exp_rd)
				report_mismatch("ram.rd", 32'(v.exp_rd), 32'(ram.rd));
			if (v.chk_din && cpu_din !== v.exp_din)
				report_mismatch("cpu_din", 32'(v.exp_din), 32'(cpu_din));

			// Second cycle, latched effects
			@(posedge clk_sys);
			#2;
			exp_l = expected_audio(psg_a, psg_b, v.exp_ear, v.exp_mic, v.tape);
			exp_r = expected_audio(psg_c, psg_b, v.exp_ear, v.exp_mic, v.tape);
			if (border !== v.exp_border)
				report_mismatch("border", 32'(v.exp_border), 32'(border));
			if (audio_l !== exp_l)
				report_mismatch("audio_l", 32'(exp_l), 32'(audio_l));
			if (audio_r !== exp_r)
				report_mismatch("audio_r", 32'(exp_r), 32'(audio_r));

			rows_done++;
			@(posedge clk_sys);
			#2;
		end

		$display("Rows applied: %0d of %0d, errors: %0d", rows_done, NUM_VEC, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+verilog
+incdir+verification
verilog/zx_bus_pkg.sv
verilog/zx_mem_pkg.sv
verilog/zx_paging.sv
verilog/zx_mem_map.sv
verilog/zx_io_read.sv
verilog/zx_ula_audio.sv
verilog/zx_host.sv
verification/tb_zx_host.sv

// File: Makefile
# Verilator build and run for the ZX Spectrum 128 host testbench
# Every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_zx_host
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
